//--- filelist.f
source/execPkg.sv
source/intAlu.sv
source/divider.sv
source/multiplier.sv
source/execLane.sv
source/branchResolve.sv
source/execCluster.sv
sim/execClusterTb.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the execCluster testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module execClusterTb -f filelist.f -o simExec
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simExec > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

//--- sim/execClusterTb.sv
`timescale 1ns/1ps
`default_nettype none

module execClusterTb;

import execPkg::*;

localparam int ALU_OPS = 40;
localparam int MUL_OPS = 10;
localparam int DIV_COUNT = 12;
localparam int DIV_LONG_ALU = 40; // keeps the slot busy past the divider finish
localparam int RESET_CYC = 10;
localparam int ALU_CYC = ALU_OPS + 4;
localparam int MUL_CYC = 2 * MUL_OPS + 6;
localparam int DIV_CYC = DIV_COUNT * (DIV_STEPS + 12) + DIV_LONG_ALU;
localparam int BR_CYC = 24;
localparam int CYCLE_LIMIT = RESET_CYC + ALU_CYC + MUL_CYC + DIV_CYC + BR_CYC + 200;

logic clk;
logic rst;
ExecUOp issueUOp0;
ExecUOp issueUOp1;
wire issueReady0;
wire issueReady1;
ExecResult wbResult0;
ExecResult wbResult1;
BranchReport branchOut;

logic [15:0] lfsr = 16'd48444;
SqN sqCnt = '0;
int cycleCnt = 0;

execCluster dut_i (
    .clk(clk),
    .rst(rst),
    .issueUOp0(issueUOp0),
    .issueUOp1(issueUOp1),
    .issueReady0(issueReady0),
    .issueReady1(issueReady1),
    .wbResult0(wbResult0),
    .wbResult1(wbResult1),
    .branchOut(branchOut)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= CYCLE_LIMIT)
        reportFail("timeout, the run exceeded its cycle limit");
end

task automatic reportFail(string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "stopped at first error");
endtask

// galois lfsr stepped once per bit
function automatic logic [31:0] randBits(int n);
    logic [31:0] val;
    logic lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
        lsb = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb)
            lfsr = lfsr ^ 16'hB400;
        val = {val[30:0], lsb};
    end
    return val;
endfunction

function automatic ExecUOp makeUOp(ExecOp op, logic [31:0] a, logic [31:0] b,
                                   logic [31:0] pc, logic [31:0] imm, logic pred);
    ExecUOp u;
    u.valid = 1'b1;
    u.sqN = sqCnt;
    u.tagDst = Tag'(randBits(TAG_W));
    u.op = op;
    u.srcA = a;
    u.srcB = b;
    u.pc = pc;
    u.imm = imm;
    u.predTaken = pred;
    sqCnt = sqCnt + 1'b1;
    return u;
endfunction

function automatic ExecResult makeResult(SqN sqN, Tag tag, logic [31:0] value);
    ExecResult r;
    r.valid = 1'b1;
    r.sqN = sqN;
    r.tagDst = tag;
    r.result = value;
    return r;
endfunction

function automatic logic [31:0] aluRef(ExecOp op, logic [31:0] a, logic [31:0] b);
    case (op)
        OP_ADD: return a + b;
        OP_SUB: return a - b;
        OP_AND: return a & b;
        OP_OR: return a | b;
        OP_XOR: return a ^ b;
        OP_SLL: return a << b[4:0];
        OP_SRL: return a >> b[4:0];
        OP_SRA: return $unsigned($signed(a) >>> b[4:0]);
        OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
        default: return '0;
    endcase
endfunction

function automatic logic [31:0] mulRef(ExecOp op, logic [31:0] a, logic [31:0] b);
    logic [63:0] p;
    p = longint'($signed(a)) * longint'($signed(b));
    return (op == OP_MULH) ? p[63:32] : p[31:0];
endfunction

// truncating divide and a remainder with the dividend's sign
function automatic logic [31:0] divRef(ExecOp op, logic [31:0] a, logic [31:0] b);
    longint sa;
    longint sb;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    case (op)
        OP_DIVU: return (b == 0) ? '1 : a / b;
        OP_REMU: return (b == 0) ? a : a % b;
        OP_DIV: return (b == 0) ? '1 : 32'(sa / sb);
        default: return (b == 0) ? a : 32'(sa % sb);
    endcase
endfunction

function automatic ExecUOp randomAluUOp();
    ExecOp op;
    op = ExecOp'(5'(randBits(4) % 10));
    return makeUOp(op, randBits(32), randBits(32), '0, '0, 1'b0);
endfunction

task automatic checkResult(string name, ExecResult got, ExecResult exp);
    if (got.valid !== exp.valid || (exp.valid && got !== exp))
        reportFail($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
endtask

task automatic checkBranch(string name, BranchReport got, BranchReport exp);
    if (got.valid !== exp.valid || (exp.valid && got !== exp))
        reportFail($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
endtask

task automatic checkBit(string name, logic got, logic exp);
    if (got !== exp)
        reportFail($sformatf("mismatch at %0t: %s expected %b got %b", $time, name, exp, got));
endtask

task automatic expectQuiet(int cycles);
    for (int i = 0; i < cycles; i++) begin
        @(negedge clk);
        checkResult("wbResult0", wbResult0, '0);
        checkResult("wbResult1", wbResult1, '0);
        checkBranch("branchOut", branchOut, '0);
    end
endtask

task automatic resetState();
    @(negedge clk);
    checkResult("wbResult0", wbResult0, '0);
    checkResult("wbResult1", wbResult1, '0);
    checkBranch("branchOut", branchOut, '0);
    checkBit("issueReady0", issueReady0, 1'b1);
    checkBit("issueReady1", issueReady1, 1'b1);
endtask

task automatic randomAluOps();
    ExecUOp u0;
    ExecUOp u1;
    ExecResult e0;
    ExecResult e1;
    ExecResult p0;
    ExecResult p1;
    p0 = '0;
    p1 = '0;
    for (int i = 0; i <= ALU_OPS; i++) begin
        @(posedge clk);
        e0 = '0;
        e1 = '0;
        if (i < ALU_OPS) begin
            u0 = randomAluUOp();
            u1 = randomAluUOp();
            issueUOp0 <= u0;
            issueUOp1 <= u1;
            e0 = makeResult(u0.sqN, u0.tagDst, aluRef(u0.op, u0.srcA, u0.srcB));
            e1 = makeResult(u1.sqN, u1.tagDst, aluRef(u1.op, u1.srcA, u1.srcB));
        end else begin
            issueUOp0 <= '0;
            issueUOp1 <= '0;
        end
        @(negedge clk);
        checkResult("wbResult0", wbResult0, p0); // op of the previous cycle
        checkResult("wbResult1", wbResult1, p1);
        checkBit("issueReady0", issueReady0, 1'b1);
        checkBit("issueReady1", issueReady1, 1'b1);
        p0 = e0;
        p1 = e1;
    end
endtask

task automatic multiplySequence();
    ExecUOp u;
    ExecResult pend[$];
    for (int i = 0; i < 2 * MUL_OPS + 2; i++) begin
        @(posedge clk);
        if (i % 2 == 0 && i < 2 * MUL_OPS) begin
            u = makeUOp((i % 4 == 0) ? OP_MUL : OP_MULH, randBits(32), randBits(32),
                        '0, '0, 1'b0);
            issueUOp1 <= u;
            pend.push_back(makeResult(u.sqN, u.tagDst, mulRef(u.op, u.srcA, u.srcB)));
        end else begin
            issueUOp1 <= '0;
        end
        @(negedge clk);
        if (i % 2 == 1 && i < 2 * MUL_OPS)
            checkBit("issueReady1", issueReady1, 1'b0); // cycle after acceptance
        else
            checkBit("issueReady1", issueReady1, 1'b1);
        if (i % 2 == 0 && i >= 2)
            checkResult("wbResult1", wbResult1, pend.pop_front());
        else
            checkResult("wbResult1", wbResult1, '0);
    end
endtask

task automatic runDivide(ExecOp op, logic [31:0] a, logic [31:0] b, int aluOps);
    ExecUOp d;
    ExecUOp u;
    ExecResult expDiv;
    ExecResult expAlu;
    ExecResult pend;
    logic finished;
    int k;
    d = makeUOp(op, a, b, '0, '0, 1'b0);
    expDiv = makeResult(d.sqN, d.tagDst, divRef(op, a, b));
    @(posedge clk);
    issueUOp0 <= d;
    pend = '0;
    finished = 1'b0;
    k = 0;
    while (!finished) begin
        @(posedge clk);
        expAlu = '0;
        if (k < aluOps) begin
            u = randomAluUOp();
            issueUOp0 <= u;
            expAlu = makeResult(u.sqN, u.tagDst, aluRef(u.op, u.srcA, u.srcB));
        end else begin
            issueUOp0 <= '0;
        end
        @(negedge clk);
        if (pend.valid) begin
            checkResult("wbResult0", wbResult0, pend);
            checkBit("issueReady0", issueReady0, 1'b0);
        end else if (wbResult0.valid) begin
            checkResult("wbResult0", wbResult0, expDiv);
            checkBit("issueReady0", issueReady0, 1'b1);
            finished = 1'b1;
        end else begin
            checkBit("issueReady0", issueReady0, 1'b0);
        end
        pend = expAlu;
        k++;
        if (k > aluOps + DIV_STEPS + 8)
            reportFail("divide result never appeared on wbResult0");
    end
endtask

task automatic divideCases();
    runDivide(OP_DIV, 32'd100, 32'd7, DIV_LONG_ALU);
    runDivide(OP_DIV, -32'sd100, 32'd7, 3);
    runDivide(OP_REM, -32'sd100, 32'd7, 2);
    runDivide(OP_REM, 32'd100, -32'sd7, 0);
    runDivide(OP_DIVU, 32'hFFFF_FFF0, 32'd3, 4);
    runDivide(OP_REMU, 32'hFFFF_FFF0, 32'd3, 1);
    runDivide(OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF, 0); // overflow case
    runDivide(OP_DIV, 32'd55, 32'd0, 2);
    runDivide(OP_REM, -32'sd5, 32'd0, 0);
    runDivide(OP_DIVU, 32'd9, 32'd0, 0);
    runDivide(OP_REMU, randBits(32), 32'd0, 1);
    runDivide(OP_DIV, randBits(32), randBits(16), 2);
endtask

task automatic singleMispredict();
    ExecUOp br;
    ExecUOp mul;
    BranchReport exp;
    br = makeUOp(OP_BEQ, 32'd5, 32'd5, 32'h1000, 32'h40, 1'b0); // taken but predicted not
    mul = makeUOp(OP_MUL, randBits(32), randBits(32), '0, '0, 1'b0);
    exp = '{valid: 1'b1, sqN: br.sqN, target: 32'h1040};
    @(posedge clk);
    issueUOp0 <= br;
    @(posedge clk);
    issueUOp0 <= '0;
    issueUOp1 <= mul;
    @(negedge clk);
    checkBranch("branchOut", branchOut, '0);
    checkResult("wbResult0", wbResult0, '0);
    @(posedge clk);
    issueUOp1 <= '0;
    @(negedge clk);
    checkBranch("branchOut", branchOut, exp);
    expectQuiet(4); // the younger multiply is gone
endtask

task automatic dualMispredict();
    ExecUOp b0;
    ExecUOp b1;
    BranchReport exp;
    sqCnt = 7'd126;
    b1 = makeUOp(OP_BLT, -32'sd3, 32'd4, 32'h3000, 32'h100, 1'b0);
    sqCnt = 7'd2; // past the wrap so younger than 126
    b0 = makeUOp(OP_BNE, 32'd1, 32'd1, 32'h2000, 32'h80, 1'b1);
    exp = '{valid: 1'b1, sqN: 7'd126, target: 32'h3100};
    @(posedge clk);
    issueUOp0 <= b0;
    issueUOp1 <= b1;
    @(posedge clk);
    issueUOp0 <= '0;
    issueUOp1 <= '0;
    @(negedge clk);
    checkBranch("branchOut", branchOut, '0);
    @(negedge clk);
    checkBranch("branchOut", branchOut, exp);
    expectQuiet(2);

    // correct predictions in both lanes
    b0 = makeUOp(OP_BGE, 32'd7, 32'd3, 32'h4000, 32'h20, 1'b1);
    b1 = makeUOp(OP_BEQ, 32'd1, 32'd2, 32'h5000, 32'h20, 1'b0);
    @(posedge clk);
    issueUOp0 <= b0;
    issueUOp1 <= b1;
    @(posedge clk);
    issueUOp0 <= '0;
    issueUOp1 <= '0;
    expectQuiet(4);
endtask

initial begin
    rst = 1'b1;
    issueUOp0 = '0;
    issueUOp1 = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    resetState();
    randomAluOps();
    multiplySequence();
    divideCases();
    singleMispredict();
    dualMispredict();

    if (cycleCnt < CYCLE_LIMIT) begin
        $display("Everything OK");
        $finish;
    end else begin
        reportFail("run ended past its cycle limit");
    end
end

endmodule

`default_nettype wire

//--- source/branchResolve.sv
`timescale 1ns/1ps
`default_nettype none

module branchResolve
(
    input wire clk,
    input wire rst,

    input wire execPkg::BranchReport branch0,
    input wire execPkg::BranchReport branch1,

    output execPkg::BranchReport branchOut,
    output logic invalidate,
    output execPkg::SqN invalidateSqN
);

import execPkg::*;

BranchReport pick;
logic use0;
logic use1;

// reports from ops the current invalidation already removes
assign use0 = branch0.valid && !isKilled(invalidate, invalidateSqN, branch0.sqN);
assign use1 = branch1.valid && !isKilled(invalidate, invalidateSqN, branch1.sqN);

always_comb begin
    if (use0 && use1)
        pick = isOlder(branch1.sqN, branch0.sqN) ? branch1 : branch0;
    else if (use1)
        pick = branch1;
    else
        pick = branch0;
    pick.valid = use0 || use1;
end

always_ff @(posedge clk) begin
    branchOut.sqN <= pick.sqN;
    branchOut.target <= pick.target;
    invalidateSqN <= pick.sqN;

    if (rst) begin
        branchOut.valid <= 1'b0;
        invalidate <= 1'b0;
    end else begin
        branchOut.valid <= pick.valid;
        invalidate <= pick.valid;
    end
end

invalidateMatchesBranch: assert property (@(posedge clk) disable iff (rst)
    invalidate == branchOut.valid);

endmodule

`default_nettype wire

//--- source/divider.sv
`timescale 1ns/1ps
`default_nettype none

module divider
(
    input wire clk,
    input wire rst,

    input wire execPkg::ExecUOp uop,
    input wire flush,
    input wire execPkg::SqN flushSqN,

    input wire slotFree,
    output wire busy,
    output execPkg::ExecResult result
);

import execPkg::*;

logic active;
logic [DIV_CNT_W-1:0] stepCnt;
logic [XLEN-1:0] quo;
logic [XLEN-1:0] rem;
logic [XLEN-1:0] dvsr;
logic negQ;
logic negR;
logic divZero;
logic wantRem;
SqN sqN;
Tag tagDst;

logic signedOp;
logic [XLEN-1:0] absA;
logic [XLEN-1:0] absB;
logic [XLEN:0] remShift;
logic [XLEN:0] remDiff;
logic done;
logic start;

assign signedOp = uop.op == OP_DIV || uop.op == OP_REM;
assign absA = (signedOp && uop.srcA[XLEN-1]) ? -uop.srcA : uop.srcA;
assign absB = (signedOp && uop.srcB[XLEN-1]) ? -uop.srcB : uop.srcB;

assign remShift = {rem, quo[XLEN-1]}; // dividend bits shift in from quo
assign remDiff = remShift - {1'b0, dvsr};

assign done = active && stepCnt == DIV_CNT_W'(DIV_STEPS);
assign start = uop.valid && !isKilled(flush, flushSqN, uop.sqN);
assign busy = active && !result.valid;

always_ff @(posedge clk) begin
    if (start) begin
        quo <= absA;
        rem <= '0;
        dvsr <= absB;
        negQ <= signedOp && (uop.srcA[XLEN-1] ^ uop.srcB[XLEN-1]);
        negR <= signedOp && uop.srcA[XLEN-1];
        divZero <= uop.srcB == '0;
        wantRem <= uop.op == OP_REM || uop.op == OP_REMU;
        sqN <= uop.sqN;
        tagDst <= uop.tagDst;
        stepCnt <= '0;
    end else if (active && !done) begin
        if (remShift >= {1'b0, dvsr}) begin
            rem <= remDiff[XLEN-1:0];
            quo <= {quo[XLEN-2:0], 1'b1};
        end else begin
            rem <= remShift[XLEN-1:0];
            quo <= {quo[XLEN-2:0], 1'b0};
        end
        stepCnt <= stepCnt + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (rst)
        active <= 1'b0;
    else if (start)
        active <= 1'b1;
    else if (result.valid || isKilled(flush, flushSqN, sqN))
        active <= 1'b0;
end

// waits here until the alu leaves the slot free
always_comb begin
    result.valid = done && slotFree;
    result.sqN = sqN;
    result.tagDst = tagDst;
    if (wantRem)
        result.result = negR ? -rem : rem;
    else if (divZero)
        result.result = '1;
    else
        result.result = negQ ? -quo : quo;
end

noStartWhileBusy: assert property (@(posedge clk) disable iff (rst)
    uop.valid |-> !busy);

endmodule

`default_nettype wire

//--- source/execCluster.sv
`timescale 1ns/1ps
`default_nettype none

module execCluster
(
    input wire clk,
    input wire rst,

    input wire execPkg::ExecUOp issueUOp0,
    input wire execPkg::ExecUOp issueUOp1,
    output wire issueReady0,
    output wire issueReady1,

    output execPkg::ExecResult wbResult0,
    output execPkg::ExecResult wbResult1,

    output execPkg::BranchReport branchOut
);

import execPkg::*;

BranchReport laneBranch0;
BranchReport laneBranch1;
wire invalidate;
SqN invalidateSqN;

// lane 0: alu + divider
execLane #(.HAS_DIVIDER(1)) lane0
(
    .clk(clk),
    .rst(rst),

    .issueUOp(issueUOp0),
    .issueReady(issueReady0),

    .flush(invalidate),
    .flushSqN(invalidateSqN),

    .wbResult(wbResult0),
    .branch(laneBranch0)
);

// lane 1: alu + multiplier
execLane #(.HAS_DIVIDER(0)) lane1
(
    .clk(clk),
    .rst(rst),

    .issueUOp(issueUOp1),
    .issueReady(issueReady1),

    .flush(invalidate),
    .flushSqN(invalidateSqN),

    .wbResult(wbResult1),
    .branch(laneBranch1)
);

branchResolve resolve
(
    .clk(clk),
    .rst(rst),

    .branch0(laneBranch0),
    .branch1(laneBranch1),

    .branchOut(branchOut),
    .invalidate(invalidate),
    .invalidateSqN(invalidateSqN)
);

endmodule

`default_nettype wire

//--- source/execLane.sv
`timescale 1ns/1ps
`default_nettype none

module execLane
#(
    parameter int HAS_DIVIDER = 1
)
(
    input wire clk,
    input wire rst,

    input wire execPkg::ExecUOp issueUOp,
    output wire issueReady,

    input wire flush,
    input wire execPkg::SqN flushSqN,

    output execPkg::ExecResult wbResult,
    output execPkg::BranchReport branch
);

import execPkg::*;

ExecUOp aluUOp;
ExecUOp unitUOp;
ExecResult aluRes;
ExecResult unitRes;
logic blocked;
logic isUnitOp;
logic accept;

assign isUnitOp = (HAS_DIVIDER != 0) ? isDiv(issueUOp.op) : isMul(issueUOp.op);
assign issueReady = !blocked;

// on the divider lane only divides wait for the divider
assign accept = issueUOp.valid && (issueReady || (HAS_DIVIDER != 0 && !isUnitOp));

always_comb begin
    aluUOp = issueUOp;
    aluUOp.valid = accept && !isDiv(issueUOp.op) && !isMul(issueUOp.op);
    unitUOp = issueUOp;
    unitUOp.valid = accept && isUnitOp;
end

intAlu ialu
(
    .clk(clk),
    .rst(rst),
    .uop(aluUOp),
    .flush(flush),
    .flushSqN(flushSqN),
    .result(aluRes),
    .branch(branch)
);

generate
    if (HAS_DIVIDER != 0) begin : genDiv
        divider div
        (
            .clk(clk),
            .rst(rst),
            .uop(unitUOp),
            .flush(flush),
            .flushSqN(flushSqN),
            .slotFree(!aluRes.valid),
            .busy(blocked),
            .result(unitRes)
        );
    end else begin : genMul
        logic mulFollow; // keeps the slot after a multiply clear of alu results

        always_ff @(posedge clk) begin
            if (rst)
                mulFollow <= 1'b0;
            else
                mulFollow <= unitUOp.valid;
        end
        assign blocked = mulFollow;

        multiplier mul
        (
            .clk(clk),
            .rst(rst),
            .uop(unitUOp),
            .flush(flush),
            .flushSqN(flushSqN),
            .result(unitRes)
        );
    end
endgenerate

assign wbResult = aluRes.valid ? aluRes : unitRes; // alu first

endmodule

`default_nettype wire

//--- source/execPkg.sv
`default_nettype none

package execPkg;

localparam XLEN = 32;
localparam SQN_W = 7;
localparam TAG_W = 6;
localparam DIV_STEPS = 32;
localparam DIV_CNT_W = $clog2(DIV_STEPS + 1);
localparam MUL_LAT = 2;

typedef logic [SQN_W-1:0] SqN;
typedef logic [TAG_W-1:0] Tag;

typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
    OP_MUL, OP_MULH,
    OP_DIV, OP_DIVU, OP_REM, OP_REMU
} ExecOp;

typedef struct packed {
    logic valid;
    SqN sqN;
    Tag tagDst;
    ExecOp op;
    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm; // branch offset
    logic predTaken;
} ExecUOp;

typedef struct packed {
    logic valid;
    SqN sqN;
    Tag tagDst;
    logic [XLEN-1:0] result;
} ExecResult;

typedef struct packed {
    logic valid; // set on mispredict only
    SqN sqN;
    logic [XLEN-1:0] target;
} BranchReport;

// wrap-around compare, a older than b
function automatic logic isOlder(SqN a, SqN b);
    SqN diff;
    diff = a - b;
    return diff[SQN_W-1];
endfunction

function automatic logic isKilled(logic flush, SqN flushSqN, SqN sqN);
    return flush && isOlder(flushSqN, sqN);
endfunction

function automatic logic isBranch(ExecOp op);
    return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE};
endfunction

function automatic logic isMul(ExecOp op);
    return op inside {OP_MUL, OP_MULH};
endfunction

function automatic logic isDiv(ExecOp op);
    return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
endfunction

endpackage

`default_nettype wire

//--- source/intAlu.sv
`timescale 1ns/1ps
`default_nettype none

module intAlu
(
    input wire clk,
    input wire rst,

    input wire execPkg::ExecUOp uop,
    input wire flush,
    input wire execPkg::SqN flushSqN,

    output execPkg::ExecResult result,
    output execPkg::BranchReport branch
);

import execPkg::*;

logic [XLEN-1:0] aluOut;
logic [XLEN-1:0] target;
logic [4:0] shamt;
logic taken;
logic live;

assign shamt = uop.srcB[4:0];
assign live = uop.valid && !isKilled(flush, flushSqN, uop.sqN);

always_comb begin
    aluOut = '0;
    taken = 1'b0;
    case (uop.op)
        OP_ADD: aluOut = uop.srcA + uop.srcB;
        OP_SUB: aluOut = uop.srcA - uop.srcB;
        OP_AND: aluOut = uop.srcA & uop.srcB;
        OP_OR: aluOut = uop.srcA | uop.srcB;
        OP_XOR: aluOut = uop.srcA ^ uop.srcB;
        OP_SLL: aluOut = uop.srcA << shamt;
        OP_SRL: aluOut = uop.srcA >> shamt;
        OP_SRA: aluOut = $signed(uop.srcA) >>> shamt;
        OP_SLT: aluOut = {{(XLEN-1){1'b0}}, $signed(uop.srcA) < $signed(uop.srcB)};
        OP_SLTU: aluOut = {{(XLEN-1){1'b0}}, uop.srcA < uop.srcB};
        OP_BEQ: taken = uop.srcA == uop.srcB;
        OP_BNE: taken = uop.srcA != uop.srcB;
        OP_BLT: taken = $signed(uop.srcA) < $signed(uop.srcB);
        OP_BGE: taken = $signed(uop.srcA) >= $signed(uop.srcB);
        default: ;
    endcase
end

// actual next pc, reported only on mispredict
assign target = taken ? uop.pc + uop.imm : uop.pc + XLEN'(4);

always_ff @(posedge clk) begin
    result.sqN <= uop.sqN;
    result.tagDst <= uop.tagDst;
    result.result <= aluOut;
    branch.sqN <= uop.sqN;
    branch.target <= target;

    if (rst) begin
        result.valid <= 1'b0;
        branch.valid <= 1'b0;
    end else begin
        result.valid <= live && !isBranch(uop.op);
        branch.valid <= live && isBranch(uop.op) && (taken != uop.predTaken);
    end
end

// branches never write back
resultOrBranch: assert property (@(posedge clk) disable iff (rst)
    !(result.valid && branch.valid));

endmodule

`default_nettype wire

//--- source/multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module multiplier
(
    input wire clk,
    input wire rst,

    input wire execPkg::ExecUOp uop,
    input wire flush,
    input wire execPkg::SqN flushSqN,

    output execPkg::ExecResult result
);

import execPkg::*;

logic [MUL_LAT-1:0] stValid;
SqN stSqN[MUL_LAT];
Tag stTag[MUL_LAT];
logic stHigh;

// signed x signed, the low word is the same for mul
logic signed [XLEN+16:0] ppLo;
logic signed [XLEN+15:0] ppHi;
logic [2*XLEN-1:0] prod;
logic [XLEN-1:0] resWord;

assign prod = {{(XLEN-17){ppLo[XLEN+16]}}, ppLo} + {ppHi, 16'b0};

always_ff @(posedge clk) begin
    ppLo <= $signed({1'b0, uop.srcA[15:0]}) * $signed(uop.srcB);
    ppHi <= $signed(uop.srcA[XLEN-1:16]) * $signed(uop.srcB);
    stHigh <= uop.op == OP_MULH;
    resWord <= stHigh ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];

    stSqN[0] <= uop.sqN;
    stTag[0] <= uop.tagDst;
    for (int i = 1; i < MUL_LAT; i++) begin
        stSqN[i] <= stSqN[i-1];
        stTag[i] <= stTag[i-1];
    end

    if (rst) begin
        stValid <= '0;
    end else begin
        stValid[0] <= uop.valid && !isKilled(flush, flushSqN, uop.sqN);
        for (int i = 1; i < MUL_LAT; i++)
            stValid[i] <= stValid[i-1] && !isKilled(flush, flushSqN, stSqN[i-1]);
    end
end

always_comb begin
    result.valid = stValid[MUL_LAT-1];
    result.sqN = stSqN[MUL_LAT-1];
    result.tagDst = stTag[MUL_LAT-1];
    result.result = resWord;
end

endmodule

`default_nettype wire
